/* verilog/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data and address width of RV32
`define RV_XLEN 32

// integer register file size
`define RV_NUM_REGS 32

// register index width
`define RV_REG_AW 5

// word count of the memory model behind the core ports
`define RV_MEM_WORDS 1024

`endif

/* verilog/rv_pkg.sv */
package rv_pkg;

  // major opcodes, insn[6:0]
  typedef enum logic [6:0] {
    op_load     = 7'b00_000_11,
    op_store    = 7'b01_000_11,
    op_branch   = 7'b11_000_11,
    op_jalr     = 7'b11_001_11,
    op_misc_mem = 7'b00_011_11,
    op_jal      = 7'b11_011_11,
    op_reg_imm  = 7'b00_100_11,
    op_reg_reg  = 7'b01_100_11,
    op_system   = 7'b11_100_11,
    op_auipc    = 7'b00_101_11,
    op_lui      = 7'b01_101_11
  } opcode_e;

  // operations selected by the decoder for the ALU
  typedef enum logic [3:0] {
    alu_add      = 4'd0,
    alu_sub      = 4'd1,
    alu_sll      = 4'd2,
    alu_slt      = 4'd3,
    alu_sltu     = 4'd4,
    alu_xor      = 4'd5,
    alu_srl      = 4'd6,
    alu_sra      = 4'd7,
    alu_or       = 4'd8,
    alu_and      = 4'd9,
    // immediate straight through, for lui
    alu_pass_imm = 4'd10,
    // pc relative, for auipc
    alu_pc_imm   = 4'd11,
    // return address of jal and jalr
    alu_link     = 4'd12
  } alu_op_e;

endpackage

/* verilog/decode_if.sv */
`include "rv_defines.svh"

interface decode_if
  import rv_pkg::*;
();

  opcode_e              opcode;
  logic [2:0]           funct3;
  alu_op_e              alu_op;
  // sign-extended immediate of whichever format the opcode uses
  logic [`RV_XLEN-1:0]  imm;
  // second ALU operand is imm instead of rs2
  logic                 use_imm;
  // already low for rd == x0
  logic                 rd_we;

  modport dec (
    output opcode, funct3, alu_op, imm, use_imm, rd_we
  );

  modport exe (
    input opcode, funct3, alu_op, imm, use_imm
  );

  modport mem (
    input opcode, funct3
  );

  modport pc (
    input opcode, imm
  );

endinterface

/* verilog/rv_decoder.sv */
`include "rv_defines.svh"

module rv_decoder
  import rv_pkg::*;
(
  input  logic [`RV_XLEN-1:0]   insn,
  output logic [`RV_REG_AW-1:0] rs1_addr,
  output logic [`RV_REG_AW-1:0] rs2_addr,
  output logic [`RV_REG_AW-1:0] rd_addr,
  output logic                  halt,
  decode_if.dec                 ctl
);

  opcode_e             opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  logic                writes_rd;

  assign opcode   = opcode_e'(insn[6:0]);
  assign rd_addr  = insn[11:7];
  assign funct3   = insn[14:12];
  assign rs1_addr = insn[19:15];
  assign rs2_addr = insn[24:20];
  assign funct7   = insn[31:25];

  // immediate formats, see the base ISA encoding table
  assign imm_i = {{(`RV_XLEN-12){insn[31]}}, insn[31:20]};
  assign imm_s = {{(`RV_XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{(`RV_XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  always_comb begin
    ctl.imm     = '0;
    ctl.use_imm = 1'b0;
    ctl.alu_op  = alu_add;
    writes_rd   = 1'b0;
    case (opcode)
      op_lui: begin
        ctl.imm    = imm_u;
        ctl.alu_op = alu_pass_imm;
        writes_rd  = 1'b1;
      end
      op_auipc: begin
        ctl.imm    = imm_u;
        ctl.alu_op = alu_pc_imm;
        writes_rd  = 1'b1;
      end
      op_jal: begin
        ctl.imm    = imm_j;
        ctl.alu_op = alu_link;
        writes_rd  = 1'b1;
      end
      op_jalr: begin
        // adder forms the target, result carries the link
        ctl.imm     = imm_i;
        ctl.use_imm = 1'b1;
        ctl.alu_op  = alu_link;
        writes_rd   = 1'b1;
      end
      op_branch: begin
        ctl.imm = imm_b;
      end
      op_load: begin
        ctl.imm     = imm_i;
        ctl.use_imm = 1'b1;
        writes_rd   = 1'b1;
      end
      op_store: begin
        ctl.imm     = imm_s;
        ctl.use_imm = 1'b1;
      end
      op_reg_imm, op_reg_reg: begin
        ctl.imm     = imm_i;
        ctl.use_imm = (opcode == op_reg_imm);
        writes_rd   = 1'b1;
        case (funct3)
          3'b000: begin
            // no subtract-immediate, bit 30 belongs to imm there
            if (opcode == op_reg_reg && funct7[5]) begin
              ctl.alu_op = alu_sub;
            end else begin
              ctl.alu_op = alu_add;
            end
          end
          3'b001: ctl.alu_op = alu_sll;
          3'b010: ctl.alu_op = alu_slt;
          3'b011: ctl.alu_op = alu_sltu;
          3'b100: ctl.alu_op = alu_xor;
          3'b101: ctl.alu_op = funct7[5] ? alu_sra : alu_srl;
          3'b110: ctl.alu_op = alu_or;
          default: ctl.alu_op = alu_and;
        endcase
      end
      op_misc_mem: begin
        // fence has nothing to order in this core
      end
      default: begin
      end
    endcase
  end

  assign ctl.opcode = opcode;
  assign ctl.funct3 = funct3;
  assign ctl.rd_we  = writes_rd && (rd_addr != '0);

  // ecall only, ebreak and csr forms do not halt
  assign halt = (opcode == op_system) && (insn[31:7] == '0);

endmodule

/* verilog/rv_regfile.sv */
`include "rv_defines.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`RV_REG_AW-1:0] rs1_addr,
  input  logic [`RV_REG_AW-1:0] rs2_addr,
  input  logic [`RV_REG_AW-1:0] rd_addr,
  input  logic                  rd_we,
  input  logic [`RV_XLEN-1:0]   rd_data,
  output logic [`RV_XLEN-1:0]   rs1_data,
  output logic [`RV_XLEN-1:0]   rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  // entry 0 is cleared by reset and never written, so x0 reads zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        if (rd_we && rd_addr == i[`RV_REG_AW-1:0]) begin
          regs[i] <= rd_data;
        end
      end
    end
  end

  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

/* verilog/rv_alu.sv */
`include "rv_defines.svh"

module rv_alu
  import rv_pkg::*;
(
  decode_if.exe               ctl,
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  output logic [`RV_XLEN-1:0] result,
  // adder output, also the jalr target
  output logic [`RV_XLEN-1:0] sum,
  output logic                br_taken
);

  logic [`RV_XLEN-1:0] op_b;
  logic [4:0]          shamt;
  logic                lt_s;
  logic                lt_u;

  assign op_b  = ctl.use_imm ? ctl.imm : rs2_data;
  assign shamt = op_b[4:0];
  assign sum   = rs1_data + op_b;

  assign lt_s = $signed(rs1_data) < $signed(op_b);
  assign lt_u = rs1_data < op_b;

  always_comb begin
    case (ctl.alu_op)
      alu_add:      result = sum;
      alu_sub:      result = rs1_data - op_b;
      alu_sll:      result = rs1_data << shamt;
      alu_slt:      result = {{(`RV_XLEN-1){1'b0}}, lt_s};
      alu_sltu:     result = {{(`RV_XLEN-1){1'b0}}, lt_u};
      alu_xor:      result = rs1_data ^ op_b;
      alu_srl:      result = rs1_data >> shamt;
      alu_sra:      result = $unsigned($signed(rs1_data) >>> shamt);
      alu_or:       result = rs1_data | op_b;
      alu_and:      result = rs1_data & op_b;
      alu_pass_imm: result = ctl.imm;
      alu_pc_imm:   result = pc + ctl.imm;
      alu_link:     result = pc + `RV_XLEN'd4;
      default:      result = sum;
    endcase
  end

  // branches always compare the two registers
  always_comb begin
    br_taken = 1'b0;
    if (ctl.opcode == op_branch) begin
      case (ctl.funct3)
        3'b000: br_taken = rs1_data == rs2_data;
        3'b001: br_taken = rs1_data != rs2_data;
        3'b100: br_taken = $signed(rs1_data) < $signed(rs2_data);
        3'b101: br_taken = $signed(rs1_data) >= $signed(rs2_data);
        3'b110: br_taken = rs1_data < rs2_data;
        3'b111: br_taken = rs1_data >= rs2_data;
        default: br_taken = 1'b0;
      endcase
    end
  end

endmodule

/* verilog/rv_mem_stage.sv */
`include "rv_defines.svh"

module rv_mem_stage
  import rv_pkg::*;
(
  decode_if.mem               ctl,
  input  logic [`RV_XLEN-1:0] alu_result,
  input  logic [`RV_XLEN-1:0] rs2_data,
  output logic [`RV_XLEN-1:0] dmem_addr,
  output logic [`RV_XLEN-1:0] dmem_wdata,
  output logic [3:0]          dmem_we,
  input  logic [`RV_XLEN-1:0] dmem_rdata,
  output logic [`RV_XLEN-1:0] wb_data
);

  logic [1:0]          byte_off;
  logic [4:0]          bit_off;
  logic [3:0]          size_mask;
  logic [`RV_XLEN-1:0] load_shifted;
  logic [`RV_XLEN-1:0] load_val;

  assign byte_off  = alu_result[1:0];
  assign bit_off   = {byte_off, 3'b000};
  assign dmem_addr = {alu_result[`RV_XLEN-1:2], 2'b00};

  // store data moves up to its byte lane
  assign dmem_wdata = rs2_data << bit_off;

  // funct3[1:0] gives the access size for both loads and stores
  always_comb begin
    case (ctl.funct3[1:0])
      2'b00:   size_mask = 4'b0001;
      2'b01:   size_mask = 4'b0011;
      default: size_mask = 4'b1111;
    endcase
  end

  assign dmem_we = (ctl.opcode == op_store) ? (size_mask << byte_off) : 4'b0000;

  assign load_shifted = dmem_rdata >> bit_off;

  always_comb begin
    case (ctl.funct3)
      3'b000:  load_val = {{(`RV_XLEN-8){load_shifted[7]}}, load_shifted[7:0]};
      3'b001:  load_val = {{(`RV_XLEN-16){load_shifted[15]}}, load_shifted[15:0]};
      3'b100:  load_val = {{(`RV_XLEN-8){1'b0}}, load_shifted[7:0]};
      3'b101:  load_val = {{(`RV_XLEN-16){1'b0}}, load_shifted[15:0]};
      default: load_val = load_shifted;
    endcase
  end

  assign wb_data = (ctl.opcode == op_load) ? load_val : alu_result;

endmodule

/* verilog/rv_fetch.sv */
`include "rv_defines.svh"

module rv_fetch
  import rv_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  decode_if.pc                ctl,
  input  logic                br_taken,
  input  logic [`RV_XLEN-1:0] alu_result,
  output logic [`RV_XLEN-1:0] pc
);

  logic [`RV_XLEN-1:0] next_pc;

  always_comb begin
    if (ctl.opcode == op_jal || br_taken) begin
      next_pc = pc + ctl.imm;
    end else if (ctl.opcode == op_jalr) begin
      // jalr drops bit 0 of the computed target
      next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
    end else begin
      next_pc = pc + `RV_XLEN'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

/* verilog/rv_core.sv */
`include "rv_defines.svh"

module rv_core (
  input  logic                clk,
  input  logic                rst,
  output logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] insn,
  output logic [`RV_XLEN-1:0] dmem_addr,
  input  logic [`RV_XLEN-1:0] dmem_rdata,
  output logic [`RV_XLEN-1:0] dmem_wdata,
  output logic [3:0]          dmem_we,
  output logic                halt
);

  logic [`RV_REG_AW-1:0] rs1_addr;
  logic [`RV_REG_AW-1:0] rs2_addr;
  logic [`RV_REG_AW-1:0] rd_addr;
  logic [`RV_XLEN-1:0]   rs1_data;
  logic [`RV_XLEN-1:0]   rs2_data;
  logic [`RV_XLEN-1:0]   alu_result;
  logic [`RV_XLEN-1:0]   alu_sum;
  logic [`RV_XLEN-1:0]   wb_data;
  logic                  br_taken;

  decode_if ctl ();

  rv_decoder u_decoder (
    .insn     (insn),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .halt     (halt),
    .ctl      (ctl)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .rd_we    (ctl.rd_we),
    .rd_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu u_alu (
    .ctl      (ctl),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (alu_result),
    .sum      (alu_sum),
    .br_taken (br_taken)
  );

  rv_mem_stage u_mem_stage (
    .ctl        (ctl),
    .alu_result (alu_result),
    .rs2_data   (rs2_data),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata),
    .wb_data    (wb_data)
  );

  // fetch takes the raw adder output so jalr keeps its link in alu_result
  rv_fetch u_fetch (
    .clk        (clk),
    .rst        (rst),
    .ctl        (ctl),
    .br_taken   (br_taken),
    .alu_result (alu_sum),
    .pc         (pc)
  );

endmodule

/* tb/tb_mem.sv */
`include "rv_defines.svh"

module tb_mem (
  input  logic                clk,
  input  logic [`RV_XLEN-1:0] pc,
  output logic [`RV_XLEN-1:0] insn,
  input  logic [`RV_XLEN-1:0] addr,
  output logic [`RV_XLEN-1:0] rdata,
  input  logic [`RV_XLEN-1:0] wdata,
  input  logic [3:0]          we
);
  timeunit 1ns;
  timeprecision 1ps;

  // one shared word array for program and data, 4 KB
  logic [`RV_XLEN-1:0] words [`RV_MEM_WORDS];
  int unsigned         store_count;

  assign insn  = words[pc[11:2]];
  assign rdata = words[addr[11:2]];

  // byte lanes written at the edge that ends the store cycle
  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (we[b]) begin
        words[addr[11:2]][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
    if (we != 4'b0000) begin
      store_count <= store_count + 1;
    end
  end

  // zero decodes as no store and no halt
  task automatic clear();
    for (int i = 0; i < `RV_MEM_WORDS; i++) begin
      words[i] = '0;
    end
    store_count = 0;
  endtask

  task automatic write_word(input logic [`RV_XLEN-1:0] a, input logic [`RV_XLEN-1:0] d);
    words[a[11:2]] = d;
  endtask

  function automatic logic [`RV_XLEN-1:0] read_word(input logic [`RV_XLEN-1:0] a);
    return words[a[11:2]];
  endfunction

endmodule

/* tb/tb_rv_core.sv */
`include "rv_defines.svh"

module tb_rv_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          NUM_TESTS = 5;
  localparam logic [31:0] RES_BASE  = 32'h400;
  localparam logic [6:0]  OP_IMM    = 7'b0010011;
  localparam logic [6:0]  OP_REG    = 7'b0110011;
  localparam logic [6:0]  OP_LOAD   = 7'b0000011;
  localparam logic [6:0]  OP_STORE  = 7'b0100011;

  logic        clk;
  logic        rst;
  logic [31:0] pc;
  logic [31:0] insn;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_rdata;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_we;
  logic        halt;
  logic [9:0]  pc_idx;

  // per instruction word: expected byte enables and jump targets
  logic [3:0]  exp_we [`RV_MEM_WORDS];
  logic        jv [`RV_MEM_WORDS];
  logic [31:0] jt [`RV_MEM_WORDS];

  logic [31:0] chk_addr [$];
  logic [31:0] chk_val [$];
  int          chk_test [$];
  int          errs [NUM_TESTS] = '{default: 0};
  string       names [NUM_TESTS];
  int          seed;
  logic [31:0] pp;
  logic [31:0] res_ptr;
  logic [31:0] ecall_pc;

  rv_core u_dut (
    .clk        (clk),
    .rst        (rst),
    .pc         (pc),
    .insn       (insn),
    .dmem_addr  (dmem_addr),
    .dmem_rdata (dmem_rdata),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .halt       (halt)
  );

  tb_mem u_mem (
    .clk   (clk),
    .pc    (pc),
    .insn  (insn),
    .addr  (dmem_addr),
    .rdata (dmem_rdata),
    .wdata (dmem_wdata),
    .we    (dmem_we)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  assign pc_idx = pc[11:2];

  // pc holds zero once the first reset edge has passed
  assert property (@(posedge clk) rst && $past(rst) |-> pc == 32'h0)
    else begin
      errs[0]++;
      $display("FAILED reset_idle expected %h actual %h", 32'h0, $sampled(pc));
    end

  // first cycle after reset still fetches from zero
  assert property (@(posedge clk) $fell(rst) |-> pc == 32'h0)
    else begin
      errs[0]++;
      $display("FAILED reset_idle expected %h actual %h", 32'h0, $sampled(pc));
    end

  assert property (@(posedge clk) insn[6:0] != OP_STORE |-> dmem_we == 4'b0000)
    else begin
      errs[0]++;
      $display("FAILED reset_idle expected %h actual %h", 4'h0, $sampled(dmem_we));
    end

  assert property (@(posedge clk) insn != 32'h0000_0073 |-> !halt)
    else begin
      errs[0]++;
      $display("FAILED reset_idle expected %h actual %h", 1'b0, $sampled(halt));
    end

  assert property (@(posedge clk) disable iff (rst)
    insn[6:0] == OP_STORE |-> dmem_we == exp_we[pc_idx])
    else begin
      errs[2]++;
      $display("FAILED byte_half expected %h actual %h",
               exp_we[$sampled(pc_idx)], $sampled(dmem_we));
    end

  // data port address is word aligned even for byte and half accesses
  assert property (@(posedge clk) disable iff (rst) dmem_addr[1:0] == 2'b00)
    else begin
      errs[2]++;
      $display("FAILED byte_half expected %h actual %h", 2'b00, $sampled(dmem_addr[1:0]));
    end

  // pc after a jump or branch against the target the builder recorded
  assert property (@(posedge clk) disable iff (rst)
    !$past(rst) && jv[$past(pc_idx)] |-> pc == jt[$past(pc_idx)])
    else begin
      errs[3]++;
      $display("FAILED control_flow expected %h actual %h",
               jt[$past(pc_idx)], $sampled(pc));
    end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // RV32I integer result, alt selects sub and sra
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic br_ref(input logic [2:0] f3, input logic [31:0] a,
                                  input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic emit(input logic [31:0] w);
    u_mem.write_word(pp, w);
    pp = pp + 4;
  endtask

  task automatic emit_jump(input logic [31:0] w, input logic [31:0] target);
    jv[pp[11:2]] = 1'b1;
    jt[pp[11:2]] = target;
    emit(w);
  endtask

  task automatic emit_store(input logic [2:0] f3, input logic [4:0] rs2,
                            input logic [31:0] a, input logic [3:0] we);
    exp_we[pp[11:2]] = we;
    emit(enc_s(a[11:0], rs2, 5'd0, f3));
  endtask

  // lui plus addi, upper part rounded for the sign of the low 12 bits
  task automatic load_imm(input logic [4:0] rd, input logic [31:0] val);
    logic [31:0] hi;
    hi = (val + 32'h800) >> 12;
    emit(enc_u(hi[19:0], rd, 7'b0110111));
    emit(enc_i(val[11:0], rd, 3'd0, rd, OP_IMM));
  endtask

  task automatic store_result(input logic [4:0] rs, input logic [31:0] exp, input int t);
    emit_store(3'b010, rs, res_ptr, 4'b1111);
    chk_addr.push_back(res_ptr);
    chk_val.push_back(exp);
    chk_test.push_back(t);
    res_ptr = res_ptr + 4;
  endtask

  task automatic build_alu();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [11:0] imm;
    a = $random(seed);
    b = $random(seed);
    load_imm(5'd1, a);
    load_imm(5'd2, b);
    for (int f = 0; f < 8; f++) begin
      emit(enc_r(7'h00, 5'd2, 5'd1, f[2:0], 5'd3));
      store_result(5'd3, alu_ref(f[2:0], 1'b0, a, b), 1);
      if (f == 0 || f == 5) begin
        emit(enc_r(7'h20, 5'd2, 5'd1, f[2:0], 5'd3));
        store_result(5'd3, alu_ref(f[2:0], 1'b1, a, b), 1);
      end
    end
    for (int f = 0; f < 8; f++) begin
      r = $random(seed);
      imm = r[11:0];
      if (f == 1 || f == 5) begin
        imm[11:5] = 7'h00;
      end
      emit(enc_i(imm, 5'd1, f[2:0], 5'd3, OP_IMM));
      store_result(5'd3, alu_ref(f[2:0], 1'b0, a, {{20{imm[11]}}, imm}), 1);
      if (f == 5) begin
        imm[11:5] = 7'h20;
        emit(enc_i(imm, 5'd1, 3'd5, 5'd3, OP_IMM));
        store_result(5'd3, alu_ref(3'd5, 1'b1, a, {20'h0, imm}), 1);
      end
    end
    // x0 ignores the write
    emit(enc_i(12'h005, 5'd1, 3'd0, 5'd0, OP_IMM));
    store_result(5'd0, 32'h0, 1);
  endtask

  task automatic build_byte_half();
    logic [31:0] base;
    logic [31:0] v;
    logic [31:0] e;
    logic [31:0] w;
    logic [31:0] ld;
    base = $random(seed);
    v = $random(seed);
    // mixed byte and half signs for the extension checks
    base[7] = 1'b1;
    base[15] = 1'b1;
    base[23] = 1'b0;
    base[31] = 1'b0;
    load_imm(5'd4, base);
    load_imm(5'd5, v);
    for (int k = 0; k < 4; k++) begin
      e = base;
      e[8*k +: 8] = v[7:0];
      w = res_ptr;
      store_result(5'd4, e, 2);
      emit_store(3'b000, 5'd5, w + k, 4'b0001 << k);
    end
    for (int k = 0; k < 3; k++) begin
      e = base;
      e[8*k +: 16] = v[15:0];
      w = res_ptr;
      store_result(5'd4, e, 2);
      emit_store(3'b001, 5'd5, w + k, 4'b0011 << k);
    end
    w = res_ptr;
    store_result(5'd4, base, 2);
    for (int k = 0; k < 4; k++) begin
      ld = base >> (8 * k);
      emit(enc_i(w[11:0] + 12'(k), 5'd0, 3'b000, 5'd6, OP_LOAD));
      store_result(5'd6, {{24{ld[7]}}, ld[7:0]}, 2);
      emit(enc_i(w[11:0] + 12'(k), 5'd0, 3'b100, 5'd6, OP_LOAD));
      store_result(5'd6, {24'h0, ld[7:0]}, 2);
    end
    for (int k = 0; k < 4; k += 2) begin
      ld = base >> (8 * k);
      emit(enc_i(w[11:0] + 12'(k), 5'd0, 3'b001, 5'd6, OP_LOAD));
      store_result(5'd6, {{16{ld[15]}}, ld[15:0]}, 2);
      emit(enc_i(w[11:0] + 12'(k), 5'd0, 3'b101, 5'd6, OP_LOAD));
      store_result(5'd6, {16'h0, ld[15:0]}, 2);
    end
    emit(enc_i(w[11:0], 5'd0, 3'b010, 5'd6, OP_LOAD));
    store_result(5'd6, base, 2);
  endtask

  task automatic build_control();
    logic [2:0]  f3_list [6];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] p;
    logic [31:0] tgt;
    logic [11:0] mk_t;
    logic [11:0] mk_nt;
    logic        tk;
    int          n;
    f3_list = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    n = 0;
    for (int i = 0; i < 6; i++) begin
      for (int t = 0; t < 2; t++) begin
        tk = (t == 0);
        a = $random(seed);
        b = $random(seed);
        a[31] = 1'b1;
        b[31] = 1'b0;
        if (br_ref(f3_list[i], a, b) != tk) begin
          if (br_ref(f3_list[i], b, a) == tk) begin
            p = a;
            a = b;
            b = p;
          end else begin
            b = a;
          end
        end
        mk_t = 12'h100 + 12'(2 * n);
        mk_nt = mk_t + 12'h1;
        n++;
        load_imm(5'd1, a);
        load_imm(5'd2, b);
        p = pp;
        emit_jump(enc_b(13'd12, 5'd2, 5'd1, f3_list[i]), tk ? p + 12 : p + 4);
        emit(enc_i(mk_nt, 5'd0, 3'd0, 5'd8, OP_IMM));
        emit_jump(enc_j(21'd8, 5'd0), p + 16);
        emit(enc_i(mk_t, 5'd0, 3'd0, 5'd8, OP_IMM));
        store_result(5'd8, tk ? {20'h0, mk_t} : {20'h0, mk_nt}, 3);
      end
    end
    p = pp;
    emit_jump(enc_j(21'd8, 5'd9), p + 8);
    emit(enc_i(12'h001, 5'd0, 3'd0, 5'd10, OP_IMM));
    store_result(5'd9, p + 4, 3);
    // jalr with offset 1, target bit 0 dropped
    tgt = pp + 16;
    load_imm(5'd11, tgt);
    p = pp;
    emit_jump(enc_i(12'h001, 5'd11, 3'd0, 5'd12, 7'b1100111), tgt);
    emit(enc_i(12'h001, 5'd0, 3'd0, 5'd10, OP_IMM));
    store_result(5'd12, p + 4, 3);
  endtask

  task automatic build_upper();
    logic [31:0] r;
    logic [31:0] p;
    r = $random(seed);
    emit(enc_u(r[19:0], 5'd13, 7'b0110111));
    store_result(5'd13, {r[19:0], 12'h0}, 4);
    r = $random(seed);
    p = pp;
    emit(enc_u(r[19:0], 5'd14, 7'b0010111));
    store_result(5'd14, p + {r[19:0], 12'h0}, 4);
    ecall_pc = pp;
    emit(32'h0000_0073);
  endtask

  initial begin
    int          cycles;
    int          failed;
    logic [31:0] got;
    seed = 37889;
    names = '{"reset_idle", "alu_ops", "byte_half", "control_flow", "lui_auipc_halt"};
    rst = 1'b1;
    u_mem.clear();
    for (int i = 0; i < `RV_MEM_WORDS; i++) begin
      exp_we[i] = 4'b0000;
      jv[i] = 1'b0;
      jt[i] = 32'h0;
    end
    pp = 32'h0;
    res_ptr = RES_BASE;
    build_alu();
    build_byte_half();
    build_control();
    build_upper();

    repeat (3) @(negedge clk);
    rst = 1'b0;

    cycles = 0;
    while (!halt && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      errs[4]++;
      $display("halt was not raised within 2000 cycles");
    end else begin
      assert (pc == ecall_pc)
        else begin
          errs[4]++;
          $display("FAILED lui_auipc_halt expected %h actual %h", ecall_pc, pc);
        end
    end

    foreach (chk_addr[i]) begin
      got = u_mem.read_word(chk_addr[i]);
      assert (got == chk_val[i])
        else begin
          errs[chk_test[i]]++;
          $display("FAILED %s expected %h actual %h", names[chk_test[i]], chk_val[i], got);
        end
    end

    failed = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      $display("test %-15s %s, %0d errors", names[t], (errs[t] == 0) ? "ok" : "bad", errs[t]);
      if (errs[t] != 0) begin
        failed++;
      end
    end
    $display("tests %0d, passed %0d, failed %0d, stores %0d",
             NUM_TESTS, NUM_TESTS - failed, failed, u_mem.store_count);
    if (failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+verilog
verilog/rv_pkg.sv
verilog/decode_if.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_mem_stage.sv
verilog/rv_fetch.sv
verilog/rv_core.sv
tb/tb_mem.sv
tb/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# build and run the RV32I core testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core \
  -f all.f -o sim_rv_core \
  && ./obj_dir/sim_rv_core > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
exit 0
